// File: pipe_pkg.sv
package pipe_pkg;

    // width of an instruction tag.
    localparam int tag_w = 8;

    // stage controls from the hazard unit.
    // pc_stall holds the F slot and if_id_stall holds the D slot.
    // if_flush marks the instruction leaving F in that cycle.
    typedef struct packed {
        logic pc_stall;
        logic if_id_stall;
        logic if_flush;
    } pipe_ctrl_t;

endpackage

// File: trace_pkg.sv
package trace_pkg;

    // width of the free-running cycle counter.
    localparam int cycle_w = 32;

    // stall counters saturate at their all-ones value.
    localparam int stall_cnt_w = 4;

    // retire buffer geometry.
    localparam int buf_depth = 8;
    localparam int buf_ptr_w = $clog2(buf_depth);
    localparam int buf_cnt_w = $clog2(buf_depth + 1);

    // one completed instruction as seen at write-back.
    typedef struct packed {
        logic [pipe_pkg::tag_w-1:0] tag;
        logic [cycle_w-1:0]         fetch_cycle;
        logic [cycle_w-1:0]         retire_cycle;
        logic [stall_cnt_w-1:0]     fetch_stalls;
        logic [stall_cnt_w-1:0]     decode_stalls;
        logic                       flushed;
    } retire_rec_t;

endpackage

// File: hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  logic                 load_use,
    input  logic                 branch_taken,
    output pipe_pkg::pipe_ctrl_t ctrl
);

    logic stall;
    logic flush;

    // a load-use hazard freezes both fetch and decode together.
    assign stall = load_use;

    // load-use wins over a taken branch.
    // the branch is seen again once the stall clears, so nothing is lost.
    assign flush = branch_taken && !load_use;

    always_comb begin
        ctrl             = '0;
        ctrl.pc_stall    = stall;
        ctrl.if_id_stall = stall;
        ctrl.if_flush    = flush;
    end

endmodule

// File: pipeline_tracker.sv
`timescale 1ns/1ps

module pipeline_tracker (
    input  logic                       clk,
    input  logic                       rst,
    input  pipe_pkg::pipe_ctrl_t       ctrl,
    input  logic                       fetch_req,
    input  logic [pipe_pkg::tag_w-1:0] fetch_tag,
    output logic                       fetch_accept,
    output logic                       push,
    output trace_pkg::retire_rec_t     push_rec
);

    logic [trace_pkg::cycle_w-1:0] cycle_cnt;

    // slot occupancy.
    logic f_valid;
    logic d_valid;
    logic e_valid;
    logic m_valid;
    logic w_valid;

    // partial records carried along with each slot.
    trace_pkg::retire_rec_t f_rec;
    trace_pkg::retire_rec_t d_rec;
    trace_pkg::retire_rec_t e_rec;
    trace_pkg::retire_rec_t m_rec;
    trace_pkg::retire_rec_t w_rec;

    logic d_move;
    logic d_free;
    logic f_move;
    logic f_open;

    function automatic logic [trace_pkg::stall_cnt_w-1:0] sat_inc(
        input logic [trace_pkg::stall_cnt_w-1:0] v
    );
        logic [trace_pkg::stall_cnt_w-1:0] r;
        if (&v) begin
            r = v;
        end else begin
            r = v + trace_pkg::stall_cnt_w'(1);
        end
        return r;
    endfunction

    // E, M and W never hold, so only D and F need advance logic.
    assign d_move = d_valid && !ctrl.if_id_stall;
    assign d_free = !d_valid || d_move;

    // F also waits on a blocked D, should the two stalls ever differ.
    assign f_move = f_valid && !ctrl.pc_stall && d_free;
    assign f_open = !f_valid || f_move;

    assign fetch_accept = fetch_req && !ctrl.pc_stall && f_open;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + trace_pkg::cycle_w'(1);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            f_valid <= 1'b0;
            d_valid <= 1'b0;
            e_valid <= 1'b0;
            m_valid <= 1'b0;
            w_valid <= 1'b0;
        end else begin
            w_valid <= m_valid;
            m_valid <= e_valid;
            // a held D leaves a bubble in E.
            e_valid <= d_move;
            if (d_free) begin
                d_valid <= f_move;
            end
            if (f_open) begin
                f_valid <= fetch_accept;
            end
        end
    end

    always_ff @(posedge clk) begin
        w_rec <= m_rec;
        m_rec <= e_rec;
        e_rec <= d_rec;

        if (d_free) begin
            d_rec         <= f_rec;
            d_rec.flushed <= ctrl.if_flush;
        end else begin
            d_rec.decode_stalls <= sat_inc(d_rec.decode_stalls);
        end

        if (fetch_accept) begin
            f_rec.tag           <= fetch_tag;
            // the cycle in which the instruction first sits in F.
            f_rec.fetch_cycle   <= cycle_cnt + trace_pkg::cycle_w'(1);
            f_rec.retire_cycle  <= '0;
            f_rec.fetch_stalls  <= '0;
            f_rec.decode_stalls <= '0;
            f_rec.flushed       <= 1'b0;
        end else if (f_valid && !f_move) begin
            f_rec.fetch_stalls <= sat_inc(f_rec.fetch_stalls);
        end
    end

    // W retires every cycle it is occupied.
    assign push = w_valid;

    always_comb begin
        push_rec              = w_rec;
        push_rec.retire_cycle = cycle_cnt;
    end

endmodule

// File: retire_buffer.sv
`timescale 1ns/1ps

module retire_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  trace_pkg::retire_rec_t push_rec,
    input  logic                   pop,
    output logic                   rec_valid,
    output trace_pkg::retire_rec_t rec,
    output logic                   overflow
);

    trace_pkg::retire_rec_t mem [trace_pkg::buf_depth];

    logic [trace_pkg::buf_ptr_w-1:0] wr_ptr;
    logic [trace_pkg::buf_ptr_w-1:0] rd_ptr;
    logic [trace_pkg::buf_cnt_w-1:0] count;

    logic full;
    logic do_push;
    logic do_pop;

    function automatic logic [trace_pkg::buf_ptr_w-1:0] ptr_next(
        input logic [trace_pkg::buf_ptr_w-1:0] p
    );
        logic [trace_pkg::buf_ptr_w-1:0] r;
        if (p == trace_pkg::buf_ptr_w'(trace_pkg::buf_depth - 1)) begin
            r = '0;
        end else begin
            r = p + trace_pkg::buf_ptr_w'(1);
        end
        return r;
    endfunction

    assign full      = (count == trace_pkg::buf_cnt_w'(trace_pkg::buf_depth));
    assign rec_valid = (count != '0);
    assign rec       = mem[rd_ptr];

    // a push into a full buffer is dropped, even with a pop in the same cycle.
    assign do_push = push && !full;
    assign do_pop  = pop && rec_valid;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_rec;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + trace_pkg::buf_cnt_w'(1);
                2'b01:   count <= count - trace_pkg::buf_cnt_w'(1);
                default: count <= count;
            endcase
            // sticky until reset.
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

// File: trace_top.sv
`timescale 1ns/1ps

module trace_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fetch_req,
    input  logic [pipe_pkg::tag_w-1:0] fetch_tag,
    input  logic                       load_use,
    input  logic                       branch_taken,
    input  logic                       pop,
    output logic                       fetch_accept,
    output logic                       rec_valid,
    output trace_pkg::retire_rec_t     rec,
    output logic                       overflow
);

    pipe_pkg::pipe_ctrl_t   ctrl;
    logic                   push;
    trace_pkg::retire_rec_t push_rec;

    hazard_unit hazard0 (
        .load_use     (load_use),
        .branch_taken (branch_taken),
        .ctrl         (ctrl)
    );

    pipeline_tracker tracker0 (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .fetch_req    (fetch_req),
        .fetch_tag    (fetch_tag),
        .fetch_accept (fetch_accept),
        .push         (push),
        .push_rec     (push_rec)
    );

    // the buffer never pushes back on the pipeline.
    retire_buffer buffer0 (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_rec  (push_rec),
        .pop       (pop),
        .rec_valid (rec_valid),
        .rec       (rec),
        .overflow  (overflow)
    );

endmodule

// File: tb_assertions.sv
`timescale 1ns/1ps

module tb_assertions (
    input logic                 clk,
    input logic                 rst,
    input logic                 load_use,
    input pipe_pkg::pipe_ctrl_t ctrl
);

    // fetch and decode always freeze together.
    stall_pair: assert property (@(posedge clk) disable iff (rst)
        ctrl.pc_stall == ctrl.if_id_stall)
        else $error("pc_stall and if_id_stall differ");

    // a taken branch never flushes during a load-use stall.
    flush_vs_stall: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.if_flush && load_use))
        else $error("if_flush is high together with load_use");

    ctrl_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(ctrl))
        else $error("stage controls are unknown after reset");

endmodule

// File: tb_top.sv
`timescale 1ns/1ps

module tb_top;

    // reference slot with raw, unsaturated stall counts.
    typedef struct packed {
        logic                       valid;
        logic [pipe_pkg::tag_w-1:0] tag;
        int                         fetch;
        int                         fst;
        int                         dst;
        logic                       flushed;
    } slot_t;

    logic                       clk = 1'b0;
    logic                       rst = 1'b1;
    logic                       fetch_req = 1'b0;
    logic [pipe_pkg::tag_w-1:0] fetch_tag = '0;
    logic                       load_use = 1'b0;
    logic                       branch_taken = 1'b0;
    logic                       pop = 1'b0;
    logic                       fetch_accept;
    logic                       rec_valid;
    trace_pkg::retire_rec_t     rec;
    logic                       overflow;

    int                         seed = 26556;
    int                         checked = 0;
    int                         flushed_seen = 0;
    string                      test_name = "reset";
    logic [pipe_pkg::tag_w-1:0] next_tag = '0;

    // F is index 0 and W is index 4.
    slot_t                      m_slot [5];
    int                         m_cycle = 0;
    logic                       m_overflow = 1'b0;
    trace_pkg::retire_rec_t     m_buf [$];

    trace_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .fetch_req    (fetch_req),
        .fetch_tag    (fetch_tag),
        .load_use     (load_use),
        .branch_taken (branch_taken),
        .pop          (pop),
        .fetch_accept (fetch_accept),
        .rec_valid    (rec_valid),
        .rec          (rec),
        .overflow     (overflow)
    );

    bind hazard_unit tb_assertions chk0 (
        .clk      (tb_top.clk),
        .rst      (tb_top.rst),
        .load_use (load_use),
        .ctrl     (ctrl)
    );

    always #50 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        assert (act === exp)
            else stop_with_error($sformatf("FAILED %s %s: expected %b, actual %b",
                test_name, what, exp, act));
    endtask

    function automatic logic chance(input int pct);
        int r;
        r = {$random(seed)} % 100;
        return r < pct;
    endfunction

    // expected record for a slot that reaches W.
    function automatic trace_pkg::retire_rec_t expected_record(input slot_t s);
        trace_pkg::retire_rec_t r;
        int                     sat;
        sat             = (1 << trace_pkg::stall_cnt_w) - 1;
        r.tag           = s.tag;
        r.fetch_cycle   = trace_pkg::cycle_w'(s.fetch);
        // four stage moves plus every cycle held in F or D.
        r.retire_cycle  = trace_pkg::cycle_w'(s.fetch + 4 + s.fst + s.dst);
        r.fetch_stalls  = trace_pkg::stall_cnt_w'((s.fst > sat) ? sat : s.fst);
        r.decode_stalls = trace_pkg::stall_cnt_w'((s.dst > sat) ? sat : s.dst);
        r.flushed       = s.flushed;
        return r;
    endfunction

    task automatic advance_model(input logic stall, input logic flush, input logic accept);
        m_slot[4] = m_slot[3];
        m_slot[3] = m_slot[2];
        if (stall) begin
            m_slot[2] = '0;
            if (m_slot[1].valid) begin
                m_slot[1].dst = m_slot[1].dst + 1;
            end
            if (m_slot[0].valid) begin
                m_slot[0].fst = m_slot[0].fst + 1;
            end
        end else begin
            m_slot[2]         = m_slot[1];
            m_slot[1]         = m_slot[0];
            m_slot[1].flushed = flush;
            m_slot[0]         = '0;
            if (accept) begin
                m_slot[0].valid = 1'b1;
                m_slot[0].tag   = fetch_tag;
                m_slot[0].fetch = m_cycle + 1;
            end
        end
    endtask

    task automatic drive_cycles(input int cycles, input int req_pct, input int lu_pct,
                                input int bt_pct, input int pop_pct);
        repeat (cycles) begin
            @(posedge clk);
            #10;
            fetch_req    = chance(req_pct);
            fetch_tag    = next_tag;
            load_use     = chance(lu_pct);
            branch_taken = chance(bt_pct);
            pop          = chance(pop_pct);
        end
    endtask

    task automatic drain_buffer();
        int n;
        n = 0;
        while (rec_valid) begin
            drive_cycles(1, 0, 0, 0, 100);
            n++;
            assert (n <= 2 * trace_pkg::buf_depth)
                else stop_with_error("the retire buffer did not empty in time");
        end
        drive_cycles(1, 0, 0, 0, 0);
    endtask

    // steps the reference at each falling edge, where inputs and outputs are settled.
    initial begin : reference_model
        int                     n;
        logic                   stall;
        logic                   flush;
        logic                   accept;
        logic                   drop;
        trace_pkg::retire_rec_t head;
        foreach (m_slot[i]) begin
            m_slot[i] = '0;
        end
        n = 0;
        while (rst) begin
            @(negedge clk);
            n++;
            assert (n < 10) else stop_with_error("reset was not released");
        end
        forever begin
            stall  = load_use;
            flush  = branch_taken && !load_use;
            accept = fetch_req && !stall;
            check_bit("fetch_accept", accept, fetch_accept);
            check_bit("rec_valid", m_buf.size() != 0, rec_valid);
            check_bit("overflow", m_overflow, overflow);
            drop = (m_buf.size() == trace_pkg::buf_depth);
            if (pop && m_buf.size() != 0) begin
                head = m_buf.pop_front();
                assert (rec === head)
                    else stop_with_error($sformatf("FAILED %s record: expected %h, actual %h",
                        test_name, head, rec));
                checked++;
                if (head.flushed) begin
                    flushed_seen++;
                end
            end
            if (m_slot[4].valid && drop) begin
                m_overflow = 1'b1;
            end else if (m_slot[4].valid) begin
                m_buf.push_back(expected_record(m_slot[4]));
            end
            advance_model(stall, flush, accept);
            if (accept) begin
                next_tag = next_tag + pipe_pkg::tag_w'(1);
            end
            m_cycle++;
            @(negedge clk);
        end
    end

    initial begin : stimulus
        int n;
        int base;
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;
        test_name = "stall_free";
        drive_cycles(40, 70, 0, 0, 90);
        test_name = "load_use";
        drive_cycles(80, 70, 30, 0, 90);
        test_name = "flush";
        drive_cycles(80, 70, 20, 30, 90);
        drive_cycles(8, 0, 0, 0, 100);
        drain_buffer();

        test_name = "overflow";
        check_bit("overflow before fill", 1'b0, overflow);
        drive_cycles(trace_pkg::buf_depth + 4, 100, 0, 0, 0);
        n = 0;
        while (!overflow) begin
            drive_cycles(1, 0, 0, 0, 0);
            n++;
            assert (n < 20) else stop_with_error("overflow was not set by a full buffer");
        end
        drive_cycles(6, 0, 0, 0, 0);
        base = checked;
        drain_buffer();
        assert (checked - base == trace_pkg::buf_depth)
            else stop_with_error($sformatf("FAILED %s pops: expected %0d, actual %0d",
                test_name, trace_pkg::buf_depth, checked - base));
        check_bit("overflow held", 1'b1, overflow);
        assert (flushed_seen > 0) else stop_with_error("no flushed instruction was seen");
        assert (checked > 50) else stop_with_error("too few records were compared");
        $display("All checks passed");
        $finish;
    end

endmodule

// File: tb.f
pipe_pkg.sv
trace_pkg.sv
hazard_unit.sv
pipeline_tracker.sv
retire_buffer.sv
trace_top.sv
tb_assertions.sv
tb_top.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_top -o Vtb_top
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

output=$(./obj_dir/Vtb_top 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qxF "All checks passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
